/* verilog/axi_mem_pkg.sv */
package axi_mem_pkg;

  // field widths of the AXI address channels
  localparam int axi_burst_width_c = 2;
  localparam int axi_len_width_c   = 8;
  localparam int axi_size_width_c  = 3;

  // burst type encoding as the AXI spec defines it
  // 2'b11 is reserved and the pump treats it as fixed
  typedef enum logic [axi_burst_width_c-1:0] {
    e_fixed = 2'b00,
    e_incr  = 2'b01,
    e_wrap  = 2'b10
  } axi_burst_e;

  // beats in the burst minus one
  // wrap bursts only allow 1, 3, 7 and 15 here
  typedef logic [axi_len_width_c-1:0] axi_len_t;

  // log2 of the bytes moved per beat
  // 0 is one byte, 7 is 128 bytes
  typedef logic [axi_size_width_c-1:0] axi_size_t;

endpackage

/* verilog/axi_burst_pump.sv */
`timescale 1ns/10ps

module axi_burst_pump
  #(parameter addr_width_p = 32
  , parameter data_width_p = 64
  )
  (input                              clk_i
  , input                             reset_i

  // request side, one burst taken per handshake
  , input                             v_i
  , output logic                      ready_and_o
  , input [addr_width_p-1:0]          axaddr_i
  , input axi_mem_pkg::axi_burst_e    axburst_i
  , input axi_mem_pkg::axi_len_t      axlen_i
  , input axi_mem_pkg::axi_size_t     axsize_i

  // beat side, consumer advances with send_i
  , output logic                      v_o
  , input                             send_i
  , output logic [addr_width_p-1:0]   addr_o
  , output logic [data_width_p/8-1:0] mask_o
  , output logic                      first_o
  , output logic                      last_o
  );

  import axi_mem_pkg::*;

  localparam mask_width_lp = data_width_p / 8;
  // low address bits that select a byte lane inside a bus word
  localparam logic [addr_width_p-1:0] lane_sel_lp = mask_width_lp - 1;
  localparam logic [addr_width_p-1:0] addr_one_lp = 1;
  localparam logic [mask_width_lp-1:0] mask_ones_lp = '1;

  typedef enum logic {
    e_ready,
    e_send
  } state_e;

  state_e state_r;

  // burst attributes, held for the whole burst
  logic [addr_width_p-1:0] address_r;
  axi_burst_e              burst_r;
  axi_len_t                len_r;
  axi_size_t               size_r;
  axi_len_t                count_r;

  logic                    accept;
  logic                    send;
  logic [addr_width_p-1:0] address_n;

  logic [addr_width_p-1:0] number_bytes;
  logic [addr_width_p-1:0] aligned_addr;
  logic [addr_width_p-1:0] aligned_incr;
  logic [2:0]              lg_len;
  logic [3:0]              wrap_shift;
  logic [addr_width_p-1:0] wrap_bytes;
  logic [addr_width_p-1:0] lower_wrap;
  logic [addr_width_p-1:0] upper_wrap;
  logic                    do_wrap;
  logic [addr_width_p-1:0] lane_lo;
  logic [addr_width_p-1:0] lane_hi;

  assign ready_and_o = (state_r == e_ready);
  assign v_o         = (state_r == e_send);
  assign accept      = v_i & ready_and_o;
  assign send        = v_o & send_i;

  assign addr_o  = address_r;
  assign first_o = (count_r == '0);
  assign last_o  = (count_r == len_r);

  // bytes per beat and the size-aligned form of the current address
  assign number_bytes = addr_one_lp << size_r;
  assign aligned_addr = (address_r >> size_r) << size_r;
  assign aligned_incr = aligned_addr + number_bytes;

  // wrap lengths are limited to 2, 4, 8 and 16 beats
  // so a lookup replaces a general log2
  always_comb begin
    case (len_r)
      8'd1:    lg_len = 3'd1;
      8'd3:    lg_len = 3'd2;
      8'd7:    lg_len = 3'd3;
      8'd15:   lg_len = 3'd4;
      default: lg_len = 3'd0;
    endcase
  end

  // wrap window is beats times bytes per beat, always a power of two
  // every beat lies inside the window, so the current address gives its base
  assign wrap_shift = {1'b0, lg_len} + {1'b0, size_r};
  assign wrap_bytes = addr_one_lp << wrap_shift;
  assign lower_wrap = (address_r >> wrap_shift) << wrap_shift;
  assign upper_wrap = lower_wrap + wrap_bytes;
  assign do_wrap    = (aligned_incr == upper_wrap);

  // next beat address
  always_comb begin
    case (burst_r)
      e_incr:  address_n = aligned_incr;
      e_wrap:  address_n = do_wrap ? lower_wrap : aligned_incr;
      // fixed and the reserved encoding repeat the address
      default: address_n = address_r;
    endcase
  end

  // byte lanes from the address up to the end of its size-aligned container
  // the container never crosses a bus word since size fits the bus
  assign lane_lo = address_r & lane_sel_lp;
  assign lane_hi = (aligned_addr & lane_sel_lp) + number_bytes;
  assign mask_o  = (mask_ones_lp << lane_lo) & ~(mask_ones_lp << lane_hi);

  // control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
      count_r <= '0;
    end else if (accept) begin
      state_r <= e_send;
      count_r <= '0;
    end else if (send) begin
      // last beat frees the pump for the next request
      state_r <= last_o ? e_ready : e_send;
      count_r <= count_r + 8'd1;
    end
  end

  // burst attributes and beat address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      address_r <= axaddr_i;
      burst_r   <= axburst_i;
      len_r     <= axlen_i;
      size_r    <= axsize_i;
    end else if (send) begin
      address_r <= address_n;
    end
  end

endmodule

/* verilog/axi_write_channel.sv */
`timescale 1ns/10ps

module axi_write_channel
  #(parameter addr_width_p = 32
  , parameter data_width_p = 64
  , parameter mem_words_p = 256
  , localparam word_addr_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1
  )
  (input                                    clk_i
  , input                                   reset_i

  // write address channel
  , input                                   awvalid_i
  , output logic                            awready_o
  , input [addr_width_p-1:0]                awaddr_i
  , input axi_mem_pkg::axi_burst_e          awburst_i
  , input axi_mem_pkg::axi_len_t            awlen_i
  , input axi_mem_pkg::axi_size_t           awsize_i

  // write data channel
  , input                                   wvalid_i
  , output logic                            wready_o
  , input [data_width_p-1:0]                wdata_i
  , input [data_width_p/8-1:0]              wstrb_i
  // burst end comes from the pump count, wlast is not looked at
  , input                                   wlast_i

  // write response channel
  , output logic                            bvalid_o
  , input                                   bready_i

  // ram write port
  , output logic                            ram_we_o
  , output logic [word_addr_width_lp-1:0]   ram_waddr_o
  , output logic [data_width_p/8-1:0]       ram_wbe_o
  , output logic [data_width_p-1:0]         ram_wdata_o
  );

  localparam mask_width_lp = data_width_p / 8;
  localparam logic [addr_width_p-1:0] bytes_per_word_lp = mask_width_lp;
  localparam logic [addr_width_p-1:0] mem_words_lp = mem_words_p;

  logic                     pump_ready;
  logic                     pump_v;
  logic [addr_width_p-1:0]  pump_addr;
  logic [mask_width_lp-1:0] pump_mask;
  logic                     pump_last;
  logic                     w_fire;
  logic                     bvalid_r;
  logic [addr_width_p-1:0]  word_idx;

  // no new burst while the response of the last one is pending
  assign awready_o = pump_ready & ~bvalid_r;

  axi_burst_pump
    #(.addr_width_p(addr_width_p)
    , .data_width_p(data_width_p)
    )
    pump
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .v_i(awvalid_i & ~bvalid_r)
    , .ready_and_o(pump_ready)
    , .axaddr_i(awaddr_i)
    , .axburst_i(awburst_i)
    , .axlen_i(awlen_i)
    , .axsize_i(awsize_i)
    , .v_o(pump_v)
    , .send_i(wvalid_i)
    , .addr_o(pump_addr)
    , .mask_o(pump_mask)
    , .first_o()
    , .last_o(pump_last)
    );

  // data is taken whenever the pump holds a beat address
  assign wready_o = pump_v;
  assign w_fire   = wvalid_i & pump_v;

  // beat address to word index, wrapping over the memory depth
  assign word_idx = (pump_addr / bytes_per_word_lp) % mem_words_lp;

  // strobes only count inside the lanes of the beat
  assign ram_we_o    = w_fire;
  assign ram_waddr_o = word_idx[word_addr_width_lp-1:0];
  assign ram_wbe_o   = wstrb_i & pump_mask;
  assign ram_wdata_o = wdata_i;

  // response raised after the last beat, held until the master takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
    end else if (w_fire & pump_last) begin
      bvalid_r <= 1'b1;
    end else if (bready_i) begin
      bvalid_r <= 1'b0;
    end
  end

  assign bvalid_o = bvalid_r;

endmodule

/* verilog/axi_read_channel.sv */
`timescale 1ns/10ps

module axi_read_channel
  #(parameter addr_width_p = 32
  , parameter data_width_p = 64
  , parameter mem_words_p = 256
  , localparam word_addr_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1
  )
  (input                                    clk_i
  , input                                   reset_i

  // read address channel
  , input                                   arvalid_i
  , output logic                            arready_o
  , input [addr_width_p-1:0]                araddr_i
  , input axi_mem_pkg::axi_burst_e          arburst_i
  , input axi_mem_pkg::axi_len_t            arlen_i
  , input axi_mem_pkg::axi_size_t           arsize_i

  // read data channel
  , output logic                            rvalid_o
  , input                                   rready_i
  , output logic [data_width_p-1:0]         rdata_o
  , output logic                            rlast_o

  // ram read port
  , output logic                            ram_re_o
  , output logic [word_addr_width_lp-1:0]   ram_raddr_o
  , input [data_width_p-1:0]                ram_rdata_i
  );

  localparam mask_width_lp = data_width_p / 8;
  localparam logic [addr_width_p-1:0] bytes_per_word_lp = mask_width_lp;
  localparam logic [addr_width_p-1:0] mem_words_lp = mem_words_p;

  logic                    pump_v;
  logic [addr_width_p-1:0] pump_addr;
  logic                    pump_last;
  logic                    r_open;
  logic                    rvalid_r;
  logic                    rlast_r;
  logic [addr_width_p-1:0] word_idx;

  // output stage is free when empty or being drained this cycle
  assign r_open = ~rvalid_r | rready_i;

  axi_burst_pump
    #(.addr_width_p(addr_width_p)
    , .data_width_p(data_width_p)
    )
    pump
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .v_i(arvalid_i)
    , .ready_and_o(arready_o)
    , .axaddr_i(araddr_i)
    , .axburst_i(arburst_i)
    , .axlen_i(arlen_i)
    , .axsize_i(arsize_i)
    , .v_o(pump_v)
    , .send_i(r_open)
    , .addr_o(pump_addr)
    // reads return whole words, lane mask is not needed
    , .mask_o()
    , .first_o()
    , .last_o(pump_last)
    );

  // beat address to word index, wrapping over the memory depth
  assign word_idx = (pump_addr / bytes_per_word_lp) % mem_words_lp;

  // one ram read per beat sent
  assign ram_re_o    = pump_v & r_open;
  assign ram_raddr_o = word_idx[word_addr_width_lp-1:0];

  // valid and last follow the ram read by one cycle
  // stalled R keeps its beat since no read is issued
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
      rlast_r  <= 1'b0;
    end else if (ram_re_o) begin
      rvalid_r <= 1'b1;
      rlast_r  <= pump_last;
    end else if (rready_i) begin
      rvalid_r <= 1'b0;
      rlast_r  <= 1'b0;
    end
  end

  assign rvalid_o = rvalid_r;
  assign rlast_o  = rlast_r;
  // ram output register doubles as the R data register
  assign rdata_o  = ram_rdata_i;

endmodule

/* verilog/axi_byte_ram.sv */
`timescale 1ns/10ps

module axi_byte_ram
  #(parameter data_width_p = 64
  , parameter mem_words_p = 256
  , localparam word_addr_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1
  )
  (input                                    clk_i

  // write port with per-byte enables
  , input                                   we_i
  , input [word_addr_width_lp-1:0]          waddr_i
  , input [data_width_p/8-1:0]              wbe_i
  , input [data_width_p-1:0]                wdata_i

  // read port, registered output
  , input                                   re_i
  , input [word_addr_width_lp-1:0]          raddr_i
  , output logic [data_width_p-1:0]         rdata_o
  );

  localparam mask_width_lp = data_width_p / 8;

  logic [data_width_p-1:0] mem_r [mem_words_p];

  // each enabled lane takes its byte of wdata
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int i = 0; i < mask_width_lp; i++) begin
        if (wbe_i[i]) begin
          mem_r[waddr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // read and write to one word in one cycle returns the old word
  // output holds while re_i is low
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_r[raddr_i];
    end
  end

endmodule

/* verilog/axi_mem_top.sv */
`timescale 1ns/10ps

module axi_mem_top
  #(parameter addr_width_p = 32
  , parameter data_width_p = 64
  , parameter mem_words_p = 256
  )
  (input                            clk_i
  , input                           reset_i

  , input                           awvalid_i
  , output logic                    awready_o
  , input [addr_width_p-1:0]        awaddr_i
  , input axi_mem_pkg::axi_burst_e  awburst_i
  , input axi_mem_pkg::axi_len_t    awlen_i
  , input axi_mem_pkg::axi_size_t   awsize_i

  , input                           wvalid_i
  , output logic                    wready_o
  , input [data_width_p-1:0]        wdata_i
  , input [data_width_p/8-1:0]      wstrb_i
  , input                           wlast_i

  , output logic                    bvalid_o
  , input                           bready_i

  , input                           arvalid_i
  , output logic                    arready_o
  , input [addr_width_p-1:0]        araddr_i
  , input axi_mem_pkg::axi_burst_e  arburst_i
  , input axi_mem_pkg::axi_len_t    arlen_i
  , input axi_mem_pkg::axi_size_t   arsize_i

  , output logic                    rvalid_o
  , input                           rready_i
  , output logic [data_width_p-1:0] rdata_o
  , output logic                    rlast_o
  );

  localparam mask_width_lp = data_width_p / 8;
  localparam word_addr_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  // write path to ram
  logic                          ram_we;
  logic [word_addr_width_lp-1:0] ram_waddr;
  logic [mask_width_lp-1:0]      ram_wbe;
  logic [data_width_p-1:0]       ram_wdata;
  // read path to and from ram
  logic                          ram_re;
  logic [word_addr_width_lp-1:0] ram_raddr;
  logic [data_width_p-1:0]       ram_rdata;

  axi_write_channel
    #(.addr_width_p(addr_width_p)
    , .data_width_p(data_width_p)
    , .mem_words_p(mem_words_p)
    )
    wr_ch
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .awvalid_i(awvalid_i)
    , .awready_o(awready_o)
    , .awaddr_i(awaddr_i)
    , .awburst_i(awburst_i)
    , .awlen_i(awlen_i)
    , .awsize_i(awsize_i)
    , .wvalid_i(wvalid_i)
    , .wready_o(wready_o)
    , .wdata_i(wdata_i)
    , .wstrb_i(wstrb_i)
    , .wlast_i(wlast_i)
    , .bvalid_o(bvalid_o)
    , .bready_i(bready_i)
    , .ram_we_o(ram_we)
    , .ram_waddr_o(ram_waddr)
    , .ram_wbe_o(ram_wbe)
    , .ram_wdata_o(ram_wdata)
    );

  axi_read_channel
    #(.addr_width_p(addr_width_p)
    , .data_width_p(data_width_p)
    , .mem_words_p(mem_words_p)
    )
    rd_ch
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .arvalid_i(arvalid_i)
    , .arready_o(arready_o)
    , .araddr_i(araddr_i)
    , .arburst_i(arburst_i)
    , .arlen_i(arlen_i)
    , .arsize_i(arsize_i)
    , .rvalid_o(rvalid_o)
    , .rready_i(rready_i)
    , .rdata_o(rdata_o)
    , .rlast_o(rlast_o)
    , .ram_re_o(ram_re)
    , .ram_raddr_o(ram_raddr)
    , .ram_rdata_i(ram_rdata)
    );

  // shared storage, one write and one read per cycle
  axi_byte_ram
    #(.data_width_p(data_width_p)
    , .mem_words_p(mem_words_p)
    )
    ram
    (.clk_i(clk_i)
    , .we_i(ram_we)
    , .waddr_i(ram_waddr)
    , .wbe_i(ram_wbe)
    , .wdata_i(ram_wdata)
    , .re_i(ram_re)
    , .raddr_i(ram_raddr)
    , .rdata_o(ram_rdata)
    );

endmodule

/* testbench/axi_mem_tb.sv */
`timescale 1ns/10ps

module axi_mem_tb;

  import axi_mem_pkg::*;

  localparam addr_width_lp = 32;
  localparam data_width_lp = 64;
  localparam mem_words_lp  = 256;
  localparam bytes_lp      = data_width_lp / 8;
  // cycles any single wait may take before the run is stopped
  localparam timeout_lp    = 200;

  logic                     clk_i;
  logic                     reset_i;
  logic                     awvalid_i;
  logic                     awready_o;
  logic [addr_width_lp-1:0] awaddr_i;
  axi_burst_e               awburst_i;
  axi_len_t                 awlen_i;
  axi_size_t                awsize_i;
  logic                     wvalid_i;
  logic                     wready_o;
  logic [data_width_lp-1:0] wdata_i;
  logic [bytes_lp-1:0]      wstrb_i;
  logic                     wlast_i;
  logic                     bvalid_o;
  logic                     bready_i;
  logic                     arvalid_i;
  logic                     arready_o;
  logic [addr_width_lp-1:0] araddr_i;
  axi_burst_e               arburst_i;
  axi_len_t                 arlen_i;
  axi_size_t                arsize_i;
  logic                     rvalid_o;
  logic                     rready_i;
  logic [data_width_lp-1:0] rdata_o;
  logic                     rlast_o;

  // byte image of the memory as the master expects it
  logic [7:0]               model_mem [mem_words_lp*bytes_lp];
  // data and strobes of the next write burst, one entry per beat
  logic [data_width_lp-1:0] wbeat_data [$];
  logic [bytes_lp-1:0]      wbeat_strb [$];

  axi_mem_top
    #(.addr_width_p(addr_width_lp)
    , .data_width_p(data_width_lp)
    , .mem_words_p(mem_words_lp)
    )
    dut0
    (.clk_i(clk_i), .reset_i(reset_i)
    , .awvalid_i(awvalid_i), .awready_o(awready_o), .awaddr_i(awaddr_i)
    , .awburst_i(awburst_i), .awlen_i(awlen_i), .awsize_i(awsize_i)
    , .wvalid_i(wvalid_i), .wready_o(wready_o), .wdata_i(wdata_i)
    , .wstrb_i(wstrb_i), .wlast_i(wlast_i)
    , .bvalid_o(bvalid_o), .bready_i(bready_i)
    , .arvalid_i(arvalid_i), .arready_o(arready_o), .araddr_i(araddr_i)
    , .arburst_i(arburst_i), .arlen_i(arlen_i), .arsize_i(arsize_i)
    , .rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o), .rlast_o(rlast_o)
    );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic timeout_stop(string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    stop_run();
  endtask

  task automatic expect_word(string name, logic [data_width_lp-1:0] exp,
                             logic [data_width_lp-1:0] got);
    assert (got === exp) else begin
      $display("ERROR time %0t signal %s expected %h got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic expect_bit(string name, logic exp, logic got);
    assert (got === exp) else begin
      $display("ERROR time %0t signal %s expected %b got %b", $time, name, exp, got);
      stop_run();
    end
  endtask

  // byte address of beat n by the AXI burst rules
  function automatic logic [31:0] beat_addr(logic [31:0] start, axi_burst_e burst,
                                            axi_len_t len, axi_size_t size, int n);
    logic [31:0] nbytes;
    logic [31:0] total;
    logic [31:0] bound;
    logic [31:0] addr;
    nbytes = 32'd1 << size;
    total  = nbytes * (32'(len) + 32'd1);
    addr   = start;
    if ((burst == e_incr || burst == e_wrap) && n > 0) begin
      // later beats sit on size-aligned addresses
      addr = (start / nbytes) * nbytes + 32'(n) * nbytes;
      if (burst == e_wrap) begin
        bound = (start / total) * total;
        if (addr >= bound + total) begin
          addr = addr - total;
        end
      end
    end
    return addr;
  endfunction

  // lanes from the address to the end of its size-aligned container
  function automatic logic [bytes_lp-1:0] beat_mask(logic [31:0] addr, axi_size_t size);
    logic [31:0]         nbytes;
    int                  lo;
    int                  hi;
    int                  j;
    logic [bytes_lp-1:0] mask;
    nbytes = 32'd1 << size;
    lo     = int'(addr % 32'(bytes_lp));
    hi     = int'(((addr / nbytes) * nbytes) % 32'(bytes_lp) + nbytes);
    mask   = '0;
    for (j = lo; j < hi; j++) begin
      mask[j] = 1'b1;
    end
    return mask;
  endfunction

  // bus word that holds a byte address, wrapping over the memory depth
  function automatic int word_index(logic [31:0] addr);
    return int'((addr / 32'(bytes_lp)) % 32'(mem_words_lp));
  endfunction

  function automatic logic [data_width_lp-1:0] model_word(int widx);
    logic [data_width_lp-1:0] word;
    int                       j;
    for (j = 0; j < bytes_lp; j++) begin
      word[8*j +: 8] = model_mem[widx*bytes_lp + j];
    end
    return word;
  endfunction

  // queue len+1 beats of random data, every strobe set
  task automatic random_beats(int len);
    int n;
    wbeat_data.delete();
    wbeat_strb.delete();
    for (n = 0; n <= len; n++) begin
      wbeat_data.push_back({$urandom, $urandom});
      wbeat_strb.push_back('1);
    end
  endtask

  // AW, then W beats back to back, then B after bdelay cycles
  task automatic axi_write(logic [31:0] addr, axi_burst_e burst, axi_len_t len,
                           axi_size_t size, int bdelay);
    int                  cnt;
    int                  n;
    int                  j;
    int                  widx;
    logic [bytes_lp-1:0] mask;
    awvalid_i <= 1'b1;
    awaddr_i  <= addr;
    awburst_i <= burst;
    awlen_i   <= len;
    awsize_i  <= size;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > timeout_lp) begin
        timeout_stop("awready_o");
      end
    end while (!awready_o);
    awvalid_i <= 1'b0;
    for (n = 0; n <= int'(len); n++) begin
      wvalid_i <= 1'b1;
      wdata_i  <= wbeat_data[n];
      wstrb_i  <= wbeat_strb[n];
      wlast_i  <= (n == int'(len));
      cnt = 0;
      do begin
        @(posedge clk_i);
        cnt++;
        if (cnt > timeout_lp) begin
          timeout_stop("wready_o");
        end
      end while (!wready_o);
      // beat taken, apply it to the model under strobe and lane mask
      mask = beat_mask(beat_addr(addr, burst, len, size, n), size);
      widx = word_index(beat_addr(addr, burst, len, size, n));
      for (j = 0; j < bytes_lp; j++) begin
        if (wbeat_strb[n][j] && mask[j]) begin
          model_mem[widx*bytes_lp + j] = wbeat_data[n][8*j +: 8];
        end
      end
    end
    wvalid_i <= 1'b0;
    wlast_i  <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > timeout_lp) begin
        timeout_stop("bvalid_o");
      end
    end while (!bvalid_o);
    assert (cnt == 1) else begin
      $display("bvalid_o rose %0d cycles after the last W beat instead of 1", cnt);
      stop_run();
    end
    // response must hold while the master stalls
    repeat (bdelay) @(posedge clk_i);
    expect_bit("bvalid_o", 1'b1, bvalid_o);
    bready_i <= 1'b1;
    @(posedge clk_i);
    bready_i <= 1'b0;
    @(posedge clk_i);
    expect_bit("bvalid_o", 1'b0, bvalid_o);
  endtask

  // AR, then every R beat checked against the model
  task automatic axi_read(logic [31:0] addr, axi_burst_e burst, axi_len_t len,
                          axi_size_t size, bit stall);
    int cnt;
    int n;
    arvalid_i <= 1'b1;
    araddr_i  <= addr;
    arburst_i <= burst;
    arlen_i   <= len;
    arsize_i  <= size;
    rready_i  <= stall ? 1'($urandom_range(1, 0)) : 1'b1;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
      if (cnt > timeout_lp) begin
        timeout_stop("arready_o");
      end
    end while (!arready_o);
    arvalid_i <= 1'b0;
    n   = 0;
    cnt = 0;
    while (n <= int'(len)) begin
      @(posedge clk_i);
      cnt++;
      if (cnt > timeout_lp) begin
        timeout_stop("an R beat");
      end
      if (rvalid_o && rready_i) begin
        // without stalls the first beat takes 2 cycles and the rest 1
        if (!stall) begin
          assert (cnt == ((n == 0) ? 2 : 1)) else begin
            $display("R beat %0d arrived after %0d cycles", n, cnt);
            stop_run();
          end
        end
        expect_word("rdata_o", model_word(word_index(beat_addr(addr, burst, len, size, n))),
                    rdata_o);
        expect_bit("rlast_o", n == int'(len), rlast_o);
        n++;
        cnt = 0;
      end
      rready_i <= stall ? 1'($urandom_range(1, 0)) : 1'b1;
    end
    // no extra beat after the last one
    rready_i <= 1'b0;
    @(posedge clk_i);
    expect_bit("rvalid_o", 1'b0, rvalid_o);
  endtask

  task automatic reset_values_check();
    expect_bit("awready_o", 1'b1, awready_o);
    expect_bit("arready_o", 1'b1, arready_o);
    expect_bit("wready_o", 1'b0, wready_o);
    expect_bit("bvalid_o", 1'b0, bvalid_o);
    expect_bit("rvalid_o", 1'b0, rvalid_o);
  endtask

  // one 256-beat burst so that every word holds a known value
  task automatic memory_fill();
    logic [31:0] a;
    int          w;
    wbeat_data.delete();
    wbeat_strb.delete();
    for (w = 0; w < mem_words_lp; w++) begin
      a = 32'(w * bytes_lp);
      // pattern carries the whole byte address of the word
      wbeat_data.push_back({a ^ 32'h5a5a_0000, ~a});
      wbeat_strb.push_back('1);
    end
    axi_write(32'h0, e_incr, 8'd255, 3'd3, 0);
  endtask

  task automatic incr_burst_roundtrip();
    random_beats(7);
    axi_write(32'h40, e_incr, 8'd7, 3'd3, 0);
    axi_read(32'h40, e_incr, 8'd7, 3'd3, 1'b0);
  endtask

  // halfword beats from 0x203, first beat only covers lane 3
  task automatic narrow_unaligned_write();
    random_beats(3);
    axi_write(32'h203, e_incr, 8'd3, 3'd1, 0);
    axi_read(32'h200, e_incr, 8'd1, 3'd3, 1'b0);
  endtask

  // window 0x100 to 0x11f, start at 0x110 wraps back to 0x100
  task automatic wrap_burst_order();
    random_beats(3);
    axi_write(32'h110, e_wrap, 8'd3, 3'd3, 0);
    axi_read(32'h110, e_wrap, 8'd3, 3'd3, 1'b0);
    axi_read(32'h100, e_incr, 8'd3, 3'd3, 1'b0);
  endtask

  task automatic fixed_burst_repeat();
    random_beats(2);
    axi_write(32'h300, e_fixed, 8'd2, 3'd3, 0);
    axi_read(32'h300, e_fixed, 8'd2, 3'd3, 1'b0);
  endtask

  task automatic stalled_handshakes();
    random_beats(15);
    axi_write(32'h400, e_incr, 8'd15, 3'd3, 6);
    axi_read(32'h400, e_incr, 8'd15, 3'd3, 1'b1);
    // whole memory under random R stalls
    axi_read(32'h0, e_incr, 8'd255, 3'd3, 1'b1);
  endtask

  initial begin
    void'($urandom(59733));
    reset_i   <= 1'b1;
    awvalid_i <= 1'b0;
    awaddr_i  <= '0;
    awburst_i <= e_incr;
    awlen_i   <= '0;
    awsize_i  <= '0;
    wvalid_i  <= 1'b0;
    wdata_i   <= '0;
    wstrb_i   <= '0;
    wlast_i   <= 1'b0;
    bready_i  <= 1'b0;
    arvalid_i <= 1'b0;
    araddr_i  <= '0;
    arburst_i <= e_incr;
    arlen_i   <= '0;
    arsize_i  <= '0;
    rready_i  <= 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    reset_values_check();
    memory_fill();
    incr_burst_roundtrip();
    narrow_unaligned_write();
    wrap_burst_order();
    fixed_burst_repeat();
    stalled_handshakes();
    $display("Verification passed");
    $finish;
  end

endmodule

/* src.f */
verilog/axi_mem_pkg.sv
verilog/axi_burst_pump.sv
verilog/axi_write_channel.sv
verilog/axi_read_channel.sv
verilog/axi_byte_ram.sv
verilog/axi_mem_top.sv
testbench/axi_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator and run, exit status carries the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f src.f --top-module axi_mem_tb -o axi_mem_sim &&
  ./obj_dir/axi_mem_sim ||
  exit 1
